/* Makefile */
# Verilator lint and simulation for the arbitrary signal generator

VERILATOR ?= verilator
TOP       ?= asg_tb
RTL_TOP   ?= asg_top
FLIST     ?= files.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -j 0 --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

sim: $(BUILD)/V$(TOP)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
src/asg_pkg.sv
src/asg_regs.sv
src/asg_table.sv
src/asg_seq.sv
src/asg_lin.sv
src/asg_top.sv
tb/asg_checker.sv
tb/asg_tb.sv

/* src/asg_lin.sv */
/*
 * asg gain stage
 * sample times Q2.14 gain plus offset, saturated to the sample width,
 * two register stages and the valid/ready output register
 */
`timescale 1ns/100ps
`default_nettype none

module asg_lin (
  input  logic                             bus,        // clock
  input  logic                             rst_n,
  input  asg_pkg::sample_t                 smp,
  input  logic                             smp_valid,
  input  logic                             smp_last,
  input  logic                             smp_idle,   // counts as zero
  input  logic signed [asg_pkg::gain_w-1:0] mul,
  input  asg_pkg::sample_t                 sum,
  output asg_pkg::stream_t                 sto,
  input  logic                             sto_ready,
  output logic                             adv         // enable for whole pipeline
);
  import asg_pkg::*;

  localparam int unsigned prd_w   = sample_w + gain_w;
  localparam int unsigned scl_w   = prd_w - gain_f;
  localparam int          sat_max = 2**(sample_w-1) - 1;
  localparam int          sat_min = -(2**(sample_w-1));

  sample_t                 x;
  logic signed [prd_w-1:0] prd;
  logic signed [scl_w-1:0] scl_q;    // gain register
  logic signed [scl_w:0]   acc;
  sample_t                 sat;
  logic                    v2, l2;
  logic                    v3, l3;
  sample_t                 d3;       // output register

  assign x   = smp_idle ? sample_t'(0) : smp;
  assign prd = x * mul;
  assign acc = scl_q + sum;          // one guard bit

  assign sat = (acc > sat_max) ? sample_t'(sat_max) :
               (acc < sat_min) ? sample_t'(sat_min) : sample_t'(acc);

  assign adv = sto_ready | ~v3;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else if (adv) begin
      v2 <= smp_valid;
      v3 <= v2;
    end
  end

  // payload, held while stalled
  always_ff @(posedge bus) begin
    if (adv) begin
      scl_q <= scl_w'(prd >>> gain_f);  // arithmetic shift
      l2    <= smp_last;
      d3    <= sat;
      l3    <= l2;
    end
  end

  assign sto = '{valid: v3, last: l3, data: d3};

endmodule

`default_nettype wire

/* src/asg_pkg.sv */
/*
 * asg package
 * shared widths, register map and bus, stream and configuration types
 * for the single-channel arbitrary signal generator
 */
`default_nettype none

package asg_pkg;

  // widths
  localparam int unsigned sample_w = 14;      // signed sample
  localparam int unsigned cwm      = 10;      // table address bits
  localparam int unsigned cwf      = 16;      // pointer fraction bits
  localparam int unsigned ew       = 4;       // external event lines
  localparam int unsigned gain_w   = 16;      // Q2.14 gain
  localparam int unsigned gain_f   = 14;      // gain fraction bits
  localparam int unsigned ptr_w    = cwm + cwf;
  localparam int unsigned bdl_w    = cwm;     // burst data length

  // register map
  localparam logic [7:0] reg_ctl     = 8'h00;
  localparam logic [7:0] reg_msk_str = 8'h10;
  localparam logic [7:0] reg_msk_stp = 8'h14;
  localparam logic [7:0] reg_msk_trg = 8'h18;
  localparam logic [7:0] reg_siz     = 8'h20;
  localparam logic [7:0] reg_off     = 8'h24;
  localparam logic [7:0] reg_ste     = 8'h28;
  localparam logic [7:0] reg_bmode   = 8'h30;
  localparam logic [7:0] reg_bdl     = 8'h34;
  localparam logic [7:0] reg_bln     = 8'h38;
  localparam logic [7:0] reg_bnm     = 8'h3c;
  localparam logic [7:0] reg_sts_bln = 8'h40;
  localparam logic [7:0] reg_sts_bnm = 8'h44;
  localparam logic [7:0] reg_mul     = 8'h48;
  localparam logic [7:0] reg_sum     = 8'h4c;

  typedef logic signed [sample_w-1:0] sample_t;

  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;    // one cycle after request
    logic [31:0] rdata;  // valid with ack
  } bus_rsp_t;

  typedef struct packed {
    logic    valid;
    logic    last;   // final data sample of a burst
    sample_t data;
  } stream_t;

  typedef struct packed {
    logic [ptr_w-1:0]         siz;  // table size, fixed point
    logic [ptr_w-1:0]         off;  // start offset (phase)
    logic [ptr_w-1:0]         ste;  // step (frequency)
    logic                     ben;  // burst enable
    logic                     inf;  // infinite bursts
    logic [bdl_w-1:0]         bdl;  // data samples per burst
    logic [31:0]              bln;  // idle samples per burst
    logic [15:0]              bnm;  // bursts per sequence
    logic signed [gain_w-1:0] mul;
    sample_t                  sum;
  } asg_cfg_t;

  typedef struct packed {
    logic rst;
    logic str;
    logic stp;
    logic trg;
  } asg_ctl_t;

  typedef struct packed {
    logic        run;
    logic        armed;
    logic [31:0] bln;  // idle counter
    logic [15:0] bnm;  // completed bursts
  } asg_sts_t;

endpackage

`default_nettype wire

/* src/asg_regs.sv */
/*
 * asg register bank
 * configuration and event mask registers, control strobes from software
 * and external events, registered readback including status counters
 */
`timescale 1ns/100ps
`default_nettype none

module asg_regs #(
  parameter int unsigned CWM = asg_pkg::cwm,
  parameter int unsigned CWF = asg_pkg::cwf,
  parameter int unsigned EW  = asg_pkg::ew
) (
  input  logic               bus,          // clock
  input  logic               rst_n,
  input  asg_pkg::bus_req_t  bus_reg,
  output asg_pkg::bus_rsp_t  bus_reg_rsp,
  input  logic [EW-1:0]      evn_ext,      // level inputs
  input  asg_pkg::asg_sts_t  sts,
  output asg_pkg::asg_cfg_t  cfg,
  output asg_pkg::asg_ctl_t  ctl,
  output logic               evn_str,      // software start
  output logic               evn_stp,      // software stop
  output logic               evn_trg       // software trigger
);
  import asg_pkg::*;

  // field masks for the narrower registers
  localparam logic [31:0] ptr_msk = (CWM + CWF >= 32) ? '1 : (32'd1 << (CWM + CWF)) - 32'd1;
  localparam logic [31:0] bdl_msk = (CWM >= 32) ? '1 : (32'd1 << CWM) - 32'd1;

  logic [EW-1:0] msk_str;
  logic [EW-1:0] msk_stp;
  logic [EW-1:0] msk_trg;
  logic          rst_q;    // software reset strobe
  logic          ack_q;
  logic [31:0]   rdata_q;
  logic [31:0]   wdata;
  logic          wr_ctl;

  assign wdata  = bus_reg.wdata;
  assign wr_ctl = bus_reg.wen & (bus_reg.addr == reg_ctl);

  //////////////////////////////////////////////////////////////////////
  // configuration writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg     <= '0;
      msk_str <= '0;
      msk_stp <= '0;
      msk_trg <= '0;
    end else if (bus_reg.wen) begin
      case (bus_reg.addr)
        reg_msk_str: msk_str <= wdata[EW-1:0];
        reg_msk_stp: msk_stp <= wdata[EW-1:0];
        reg_msk_trg: msk_trg <= wdata[EW-1:0];
        reg_siz:     cfg.siz <= ptr_w'(wdata & ptr_msk);
        reg_off:     cfg.off <= ptr_w'(wdata & ptr_msk);
        reg_ste:     cfg.ste <= ptr_w'(wdata & ptr_msk);
        reg_bmode: begin
          cfg.ben <= wdata[0];
          cfg.inf <= wdata[1];
        end
        reg_bdl:     cfg.bdl <= bdl_w'(wdata & bdl_msk);
        reg_bln:     cfg.bln <= wdata;
        reg_bnm:     cfg.bnm <= wdata[15:0];
        reg_mul:     cfg.mul <= wdata[gain_w-1:0];
        reg_sum:     cfg.sum <= wdata[sample_w-1:0];
        default: ;                                   // status and ctl are not stored here
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rst_q   <= 1'b0;
      evn_str <= 1'b0;
      evn_stp <= 1'b0;
      evn_trg <= 1'b0;
    end else begin
      rst_q   <= wr_ctl & wdata[0];  // single cycle each
      evn_str <= wr_ctl & wdata[1];
      evn_stp <= wr_ctl & wdata[2];
      evn_trg <= wr_ctl & wdata[3];
    end
  end

  // software strobes merged with masked external lines
  assign ctl = '{rst: rst_q,
                 str: evn_str | (|(evn_ext & msk_str)),
                 stp: evn_stp | (|(evn_ext & msk_stp)),
                 trg: evn_trg | (|(evn_ext & msk_trg))};

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_reg.wen | bus_reg.ren;  // every access acked next cycle
    end
  end

  always_ff @(posedge bus) begin
    if (bus_reg.ren) begin
      case (bus_reg.addr)
        reg_ctl:     rdata_q <= {30'd0, sts.armed, sts.run};
        reg_msk_str: rdata_q <= 32'(msk_str);
        reg_msk_stp: rdata_q <= 32'(msk_stp);
        reg_msk_trg: rdata_q <= 32'(msk_trg);
        reg_siz:     rdata_q <= 32'(cfg.siz);
        reg_off:     rdata_q <= 32'(cfg.off);
        reg_ste:     rdata_q <= 32'(cfg.ste);
        reg_bmode:   rdata_q <= {30'd0, cfg.inf, cfg.ben};
        reg_bdl:     rdata_q <= 32'(cfg.bdl);
        reg_bln:     rdata_q <= cfg.bln;
        reg_bnm:     rdata_q <= {16'd0, cfg.bnm};
        reg_sts_bln: rdata_q <= sts.bln;
        reg_sts_bnm: rdata_q <= {16'd0, sts.bnm};
        reg_mul:     rdata_q <= {{(32-gain_w){1'b0}}, cfg.mul};    // raw bits, no sign
        reg_sum:     rdata_q <= {{(32-sample_w){1'b0}}, cfg.sum};
        default:     rdata_q <= '0;
      endcase
    end
  end

  assign bus_reg_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* src/asg_seq.sv */
/*
 * asg sequencer
 * armed/running control, fixed-point table pointer with wrap,
 * burst data, idle and repetition counters, per-sample flags and events
 */
`timescale 1ns/100ps
`default_nettype none

module asg_seq #(
  parameter int unsigned CWM = asg_pkg::cwm,
  parameter int unsigned CWF = asg_pkg::cwf
) (
  input  logic              bus,        // clock
  input  logic              rst_n,
  input  asg_pkg::asg_cfg_t cfg,
  input  asg_pkg::asg_ctl_t ctl,
  input  logic              adv,        // pipeline enable
  output logic [CWM-1:0]    rd_addr,
  output logic              rd_en,
  output logic              smp_valid,  // aligned with rd_data
  output logic              smp_last,
  output logic              smp_idle,
  output asg_pkg::asg_sts_t sts,
  output logic              evn_per,
  output logic              evn_lst
);
  import asg_pkg::*;

  localparam int unsigned pw = CWM + CWF;

  logic [pw-1:0]    siz, off, ste;
  logic [pw-1:0]    ptr;           // integer.fraction
  logic [pw:0]      ptr_sum;
  logic [pw-1:0]    ptr_nxt;
  logic             wrap;
  logic             run, armed, gap;
  logic [bdl_w-1:0] bdl_cnt;
  logic [31:0]      bln_cnt;
  logic [15:0]      bnm_cnt;
  logic             dat_end, gap_end, bst_end, seq_end;
  logic             issue;
  logic             per1, per2, per3;  // period flag per stage
  logic             lst1, lst2, lst3;  // sequence end flag per stage

  assign siz = pw'(cfg.siz);
  assign off = pw'(cfg.off);
  assign ste = pw'(cfg.ste);

  //////////////////////////////////////////////////////////////////////
  // pointer and burst bookkeeping
  //////////////////////////////////////////////////////////////////////

  assign ptr_sum = {1'b0, ptr} + {1'b0, ste};
  assign wrap    = ptr_sum >= {1'b0, siz};
  assign ptr_nxt = wrap ? pw'(ptr_sum - {1'b0, siz}) : pw'(ptr_sum);

  assign dat_end = cfg.ben & ~gap & (bdl_cnt == cfg.bdl - 1'b1);  // last data of burst
  assign gap_end = gap & (bln_cnt == cfg.bln - 32'd1);
  assign bst_end = (dat_end & (cfg.bln == '0)) | gap_end;
  assign seq_end = bst_end & ~cfg.inf & (bnm_cnt + 16'd1 == cfg.bnm);

  // stop and reset win over the sample on the same cycle
  assign issue = run & ~ctl.stp & ~ctl.rst;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      armed   <= 1'b0;
      gap     <= 1'b0;
      ptr     <= '0;
      bdl_cnt <= '0;
      bln_cnt <= '0;
      bnm_cnt <= '0;
    end else if (ctl.rst) begin
      run     <= 1'b0;
      armed   <= 1'b0;
      gap     <= 1'b0;
      bdl_cnt <= '0;
      bln_cnt <= '0;
      bnm_cnt <= '0;
    end else if (ctl.stp) begin
      run <= 1'b0;                               // armed stays
    end else begin
      if (ctl.str) armed <= 1'b1;
      if (ctl.trg && armed && !run) begin        // start at offset
        run     <= 1'b1;
        ptr     <= off;
        gap     <= 1'b0;
        bdl_cnt <= '0;
        bln_cnt <= '0;
        bnm_cnt <= '0;
      end else if (run && adv) begin             // frozen under back-pressure
        if (!gap) begin
          ptr     <= ptr_nxt;
          bdl_cnt <= bdl_cnt + 1'b1;
        end else begin
          bln_cnt <= bln_cnt + 32'd1;
        end
        if (dat_end && cfg.bln != '0) begin      // enter idle part
          gap     <= 1'b1;
          bln_cnt <= '0;
        end
        if (bst_end) begin                       // next burst from offset
          bnm_cnt <= bnm_cnt + 16'd1;
          gap     <= 1'b0;
          bdl_cnt <= '0;
          ptr     <= off;
          if (seq_end) run <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // flags through RAM stage, events follow the gain stage pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      smp_valid <= 1'b0;
      smp_last  <= 1'b0;
      smp_idle  <= 1'b0;
      {per1, per2, per3} <= '0;
      {lst1, lst2, lst3} <= '0;
    end else if (adv) begin
      smp_valid <= issue;
      smp_last  <= issue & dat_end;
      smp_idle  <= issue & gap;
      per1      <= issue & ~gap & wrap;  // sample whose step wraps
      lst1      <= issue & seq_end;
      per2      <= per1;                 // gain register
      lst2      <= lst1;
      per3      <= per2;                 // output register
      lst3      <= lst2;
    end
  end

  // output sample valid and adv high means it is taken this cycle
  assign evn_per = adv & per3;
  assign evn_lst = adv & lst3;

  assign rd_addr = ptr[pw-1:CWF];
  assign rd_en   = adv;
  assign sts     = '{run: run, armed: armed, bln: bln_cnt, bnm: bnm_cnt};

endmodule

`default_nettype wire

/* src/asg_table.sv */
/*
 * asg waveform table
 * dual-port synchronous RAM, CPU word access on one side and a
 * stallable read port for the sequencer on the other
 */
`timescale 1ns/100ps
`default_nettype none

module asg_table #(
  parameter int unsigned CWM = asg_pkg::cwm
) (
  input  logic              bus,          // clock
  input  logic              rst_n,
  input  asg_pkg::bus_req_t bus_tbl,
  output asg_pkg::bus_rsp_t bus_tbl_rsp,
  input  logic [CWM-1:0]    rd_addr,
  output asg_pkg::sample_t  rd_data,
  input  logic              rd_en         // pipeline enable
);
  import asg_pkg::*;

  localparam int unsigned depth = 2**CWM;

  sample_t        mem [depth];
  logic [CWM-1:0] cpu_addr;   // word address
  logic           ack_q;
  logic [31:0]    rdata_q;

  assign cpu_addr = CWM'(bus_tbl.addr[7:2]);

  // CPU port
  always_ff @(posedge bus) begin
    if (bus_tbl.wen) begin
      mem[cpu_addr] <= bus_tbl.wdata[sample_w-1:0];
    end
    if (bus_tbl.ren) begin
      rdata_q <= 32'(mem[cpu_addr]);  // sign extended
    end
  end

  // sequencer port, holds during stalls
  always_ff @(posedge bus) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_tbl.wen | bus_tbl.ren;
    end
  end

  assign bus_tbl_rsp = '{ack: ack_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* src/asg_top.sv */
/*
 * asg top level
 * register bank, waveform table, sequencer and gain stage
 */
`timescale 1ns/100ps
`default_nettype none

module asg_top #(
  parameter int unsigned CWM = asg_pkg::cwm,  // table address bits
  parameter int unsigned CWF = asg_pkg::cwf,  // pointer fraction bits
  parameter int unsigned EW  = asg_pkg::ew    // external event lines
) (
  input  logic              bus,          // clock
  input  logic              rst_n,
  input  asg_pkg::bus_req_t bus_reg,      // register access
  input  asg_pkg::bus_req_t bus_tbl,      // table access
  output asg_pkg::bus_rsp_t bus_reg_rsp,
  output asg_pkg::bus_rsp_t bus_tbl_rsp,
  input  logic [EW-1:0]     evn_ext,
  output asg_pkg::stream_t  sto,
  input  logic              sto_ready,
  output logic              evn_str,
  output logic              evn_stp,
  output logic              evn_trg,
  output logic              evn_per,
  output logic              evn_lst
);
  import asg_pkg::*;

  asg_cfg_t       cfg;
  asg_ctl_t       ctl;
  asg_sts_t       sts;
  logic [CWM-1:0] rd_addr;
  logic           rd_en;
  sample_t        rd_data;
  logic           smp_valid, smp_last, smp_idle;
  logic           adv;        // pipeline enable from output stage

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  asg_regs #(.CWM(CWM), .CWF(CWF), .EW(EW)) regs_i (
    .bus, .rst_n, .bus_reg, .bus_reg_rsp, .evn_ext, .sts,
    .cfg, .ctl, .evn_str, .evn_stp, .evn_trg
  );

  asg_table #(.CWM(CWM)) table_i (
    .bus, .rst_n, .bus_tbl, .bus_tbl_rsp,
    .rd_addr, .rd_data, .rd_en
  );

  //////////////////////////////////////////////////////////////////////
  // sequencer and output stage
  //////////////////////////////////////////////////////////////////////

  asg_seq #(.CWM(CWM), .CWF(CWF)) seq_i (
    .bus, .rst_n, .cfg, .ctl, .adv,
    .rd_addr, .rd_en,
    .smp_valid, .smp_last, .smp_idle,
    .sts, .evn_per, .evn_lst
  );

  asg_lin lin_i (
    .bus, .rst_n,
    .smp       (rd_data),
    .smp_valid, .smp_last, .smp_idle,
    .mul       (cfg.mul),
    .sum       (cfg.sum),
    .sto, .sto_ready, .adv
  );

endmodule

`default_nettype wire

/* tb/asg_checker.sv */
/*
 * asg checker
 * stream hold under stall, valid low in reset, single-cycle events
 */
`timescale 1ns/100ps
`default_nettype none

module asg_checker (
  input logic             bus,      // clock
  input logic             rst_n,
  input logic             valid,
  input logic             last,
  input asg_pkg::sample_t data,
  input logic             ready,    // or pipeline enable
  input logic             pulse_a,  // evn_per
  input logic             pulse_b   // evn_lst
);
  import asg_pkg::*;

  // stalled sample stays put
  a_hold: assert property (@(posedge bus) disable iff (!rst_n)
    valid && !ready |=> valid && $stable(data) && $stable(last))
    else $error("stream changed while stalled");

  a_rst: assert property (@(posedge bus) !rst_n |-> !valid)
    else $error("valid high during reset");

  a_per: assert property (@(posedge bus) disable iff (!rst_n) pulse_a |=> !pulse_a)
    else $error("evn_per longer than one cycle");

  a_lst: assert property (@(posedge bus) disable iff (!rst_n) pulse_b |=> !pulse_b)
    else $error("evn_lst longer than one cycle");

endmodule

bind asg_lin asg_checker lin_chk_i (.bus(bus), .rst_n(rst_n), .valid(sto.valid),
  .last(sto.last), .data(sto.data), .ready(sto_ready), .pulse_a(1'b0), .pulse_b(1'b0));

bind asg_seq asg_checker seq_chk_i (.bus(bus), .rst_n(rst_n), .valid(smp_valid),
  .last(smp_last), .data(asg_pkg::sample_t'(0)), .ready(adv),
  .pulse_a(evn_per), .pulse_b(evn_lst));

`default_nettype wire

/* tb/asg_tb.sv */
/*
 * asg testbench
 * loads a random table, runs a table of playback rows against a
 * reference model, checks readback, bursts, back-pressure and events
 */
`timescale 1ns/100ps
`default_nettype none

module asg_tb;
  import asg_pkg::*;

  typedef struct {
    string       name;
    bit          ben, inf;
    int          siz, off, ste, bdl, bln, bnm;
    logic [15:0] mul;
    logic [13:0] sum;
    bit          rdy;   // random ready
    int          n;     // samples checked
    int          evt;   // 0 none, 1 masked stop, 2 unmasked line
  } row_t;

  localparam int nrows = 12;
  localparam int ntbl  = 64;  // reachable through the 6-bit word address

  logic bus, rst_n, sto_ready;
  logic [ew-1:0] evn_ext;
  bus_req_t bus_reg, bus_tbl;
  bus_rsp_t bus_reg_rsp, bus_tbl_rsp;
  stream_t sto;
  logic evn_str, evn_stp, evn_trg, evn_per, evn_lst;

  row_t rows [nrows];
  int tbl [ntbl];           // table contents as written
  int exp_d [$];
  bit exp_l [$], exp_p [$];
  sample_t got_d [$];
  bit got_l [$], got_p [$], got_e [$];
  logic [31:0] rng = 32'd68773;
  bit rdy_rand;
  int errors, checks, wd_cycles;

  asg_top dut_i (.*);

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;  // 40 ns
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // Q2.14 gain, offset, saturate to 14 signed bits
  function automatic int gain(input int x, input logic [15:0] m, input logic [13:0] o);
    int a;
    a = ((x * int'($signed(m))) >>> 14) + int'($signed(o));
    return (a > 8191) ? 8191 : (a < -8192) ? -8192 : a;
  endfunction

  always @(negedge bus) begin
    rng = xorshift(rng);
    sto_ready = rdy_rand ? rng[7] : 1'b1;
  end

  // collect accepted samples
  always @(posedge bus) begin
    if (rst_n && sto.valid && sto_ready) begin
      got_d.push_back(sto.data);
      got_l.push_back(sto.last);
      got_p.push_back(evn_per);
      got_e.push_back(evn_lst);
    end
  end

  task automatic bus_write(input bit t, input logic [7:0] a, input logic [31:0] d);
    @(negedge bus);
    if (t) bus_tbl = '{wen: 1'b1, ren: 1'b0, addr: a, wdata: d};
    else bus_reg = '{wen: 1'b1, ren: 1'b0, addr: a, wdata: d};
    @(negedge bus);
    bus_tbl = '0;
    bus_reg = '0;
    if (!(t ? bus_tbl_rsp.ack : bus_reg_rsp.ack)) begin
      $display("no acknowledge for write to 0x%02h", a);
      errors++;
    end
  endtask

  // ctl write, the software strobes are high for the cycle after it
  task automatic ctl_write(input logic [3:0] s);
    bus_write(0, reg_ctl, 32'(s));
    checks++;
    if ({evn_trg, evn_stp, evn_str} !== s[3:1]) begin
      $display("** Error at %0t: strobes trg/stp/str %b%b%b expected %b", $time, evn_trg,
               evn_stp, evn_str, s[3:1]);
      errors++;
    end
  endtask

  task automatic bus_read(input logic [7:0] a, output logic [31:0] d);
    @(negedge bus);
    bus_reg = '{wen: 1'b0, ren: 1'b1, addr: a, wdata: 32'd0};
    @(negedge bus);
    bus_reg = '0;
    d = bus_reg_rsp.rdata;
    if (!bus_reg_rsp.ack) begin
      $display("no acknowledge for read of 0x%02h", a);
      errors++;
    end
  endtask

  task automatic wait_samples(input int n);
    int k;
    for (k = 0; k < n * 8 + 100 && got_d.size() < n; k++) @(negedge bus);
    if (got_d.size() < n) begin
      $display("timeout, only %0d of %0d samples arrived", got_d.size(), n);
      errors++;
    end
  endtask

  // reference sequence from the table and the playback rules
  task automatic build_expected(input row_t r);
    longint p;
    int b, i;
    exp_d.delete();
    exp_l.delete();
    exp_p.delete();
    p = r.off;
    for (b = 0; exp_d.size() < r.n; b++) begin
      if (r.ben) p = r.off;  // each burst restarts at off
      for (i = 0; (!r.ben || i < r.bdl) && exp_d.size() < r.n; i++) begin
        exp_d.push_back(gain(tbl[p >> 16], r.mul, r.sum));
        exp_l.push_back(r.ben && i == r.bdl - 1);
        p += r.ste;
        exp_p.push_back(p >= r.siz);
        if (p >= r.siz) p -= r.siz;
      end
      for (i = 0; r.ben && i < r.bln; i++) begin
        exp_d.push_back(gain(0, r.mul, r.sum));  // idle counts as zero
        exp_l.push_back(1'b0);
        exp_p.push_back(1'b0);
      end
    end
  endtask

  task automatic check_regs();
    logic [7:0] a [12] = '{reg_msk_str, reg_msk_stp, reg_msk_trg, reg_siz, reg_off,
      reg_ste, reg_bmode, reg_bdl, reg_bln, reg_bnm, reg_mul, reg_sum};
    logic [31:0] m [12] = '{32'hf, 32'hf, 32'hf, 32'h3ffffff, 32'h3ffffff, 32'h3ffffff,
      32'h3, 32'h3ff, 32'hffffffff, 32'hffff, 32'hffff, 32'h3fff};
    logic [31:0] v, d;
    int i;
    for (i = 0; i < 12; i++) begin
      rng = xorshift(rng);
      v = rng;
      bus_write(0, a[i], v);
      bus_read(a[i], d);
      checks++;
      if (d !== (v & m[i])) begin
        $display("** Error at %0t: reg 0x%02h read 0x%08h expected 0x%08h", $time, a[i], d,
                 v & m[i]);
        errors++;
      end
    end
  endtask

  task automatic run_row(input row_t r);
    int i, cnt, np, ne;
    logic [31:0] d, s;
    rdy_rand = 1'b0;
    ctl_write(4'h1);               // clear armed and counters
    bus_write(0, reg_msk_str, 32'h0);
    bus_write(0, reg_msk_trg, 32'h0);
    bus_write(0, reg_msk_stp, (r.evt == 1) ? 32'h1 : 32'h0);
    bus_write(0, reg_siz, r.siz);
    bus_write(0, reg_off, r.off);
    bus_write(0, reg_ste, r.ste);
    bus_write(0, reg_bmode, {30'd0, r.inf, r.ben});
    bus_write(0, reg_bdl, r.bdl);
    bus_write(0, reg_bln, r.bln);
    bus_write(0, reg_bnm, r.bnm);
    bus_write(0, reg_mul, {16'd0, r.mul});
    bus_write(0, reg_sum, {18'd0, r.sum});
    build_expected(r);
    got_d.delete();
    got_l.delete();
    got_p.delete();
    got_e.delete();
    rdy_rand = r.rdy;
    ctl_write(4'h2);               // str arms
    ctl_write(4'h8);               // trg starts
    if (r.evt == 2) begin
      wait_samples(r.n / 2);
      evn_ext[0] = 1'b1;           // unmasked, ignored
    end
    wait_samples(r.n);
    if (r.evt == 1) begin
      @(negedge bus);
      evn_ext[0] = 1'b1;
      cnt = got_d.size();
      repeat (20) @(negedge bus);
      checks++;
      if (got_d.size() - cnt > 3) begin
        $display("output went on after the masked external stop line");
        errors++;
      end
    end
    evn_ext = '0;
    if (r.ben) begin
      rdy_rand = 1'b0;
      repeat (30) @(negedge bus);
      bus_read(reg_sts_bnm, d);
      ne = 0;
      foreach (got_e[k]) ne += got_e[k];
      checks++;
      if (got_d.size() != r.n || ne != 1 || !got_e[got_e.size() - 1] || d != r.bnm) begin
        $display("** Error at %0t: %s burst end %0d samples, %0d evn_lst, status bnm %0d",
                 $time, r.name, got_d.size(), ne, d);
        errors++;
      end
      ctl_write(4'h1);             // rst clears the counters
      bus_read(reg_sts_bln, d);
      bus_read(reg_sts_bnm, s);
      checks++;
      if (d !== 0 || s !== 0) begin
        $display("** Error at %0t: status not zero after rst (%0d, %0d)", $time, d, s);
        errors++;
      end
    end
    for (i = 0; i < r.n && i < got_d.size(); i++) begin
      checks++;
      if (int'(got_d[i]) != exp_d[i] || got_l[i] != exp_l[i]) begin
        $display("** Error at %0t: %s sample %0d got %0d/%0b expected %0d/%0b", $time, r.name,
                 i, got_d[i], got_l[i], exp_d[i], exp_l[i]);
        errors++;
      end
    end
    np = 0;
    cnt = 0;
    for (i = 0; i < r.n && i < got_d.size(); i++) begin
      np += got_p[i];
      cnt += exp_p[i];
    end
    if (!r.ben) begin
      checks++;
      if (np != cnt) begin
        $display("** Error at %0t: %s evn_per count %0d expected %0d", $time, r.name, np, cnt);
        errors++;
      end
    end
    rdy_rand = 1'b0;
    ctl_write(4'h4);               // stop, then drain the pipeline
    repeat (10) @(negedge bus);
  endtask

  initial begin
    int i, e0;
    rst_n = 1'b0;
    sto_ready = 1'b1;
    evn_ext = '0;
    bus_reg = '0;
    bus_tbl = '0;
    rdy_rand = 1'b0;
    //            name        ben inf siz       off               ste       bdl bln bnm
    rows[0]  = '{"step 1",     0, 0, 48 << 16, 5 << 16, 1 << 16, 0, 0, 0, 16'h4000, 14'h0, 0, 120, 0};
    rows[1]  = '{"step 0.5",   0, 0, 40 << 16, 0, 32'h8000, 0, 0, 0, 16'h4000, 14'h0, 0, 100, 0};
    rows[2]  = '{"step 1.5",   0, 0, 64 << 16, 32'h34000, 32'h18000, 0, 0, 0, 16'h4000, 14'h0, 0,
                 100, 0};
    rows[3]  = '{"gain -1",    0, 0, 64 << 16, 0, 1 << 16, 0, 0, 0, 16'hc000, 14'd100, 0, 60, 0};
    rows[4]  = '{"gain 2",     0, 0, 64 << 16, 0, 1 << 16, 0, 0, 0, 16'h7fff, 14'h3ed4, 0, 60, 0};
    rows[5]  = '{"offset +",   0, 0, 64 << 16, 0, 1 << 16, 0, 0, 0, 16'h4000, 14'h1f00, 0, 60, 0};
    rows[6]  = '{"offset -",   0, 0, 64 << 16, 0, 1 << 16, 0, 0, 0, 16'h4000, 14'h2100, 0, 60, 0};
    rows[7]  = '{"burst",      1, 0, 32 << 16, 2 << 16, 1 << 16, 7, 4, 3, 16'h4000, 14'd25, 0, 33, 0};
    rows[8]  = '{"burst gap0", 1, 0, 32 << 16, 0, 1 << 16, 5, 0, 2, 16'h4000, 14'd0, 0, 10, 0};
    rows[9]  = '{"rand ready", 0, 0, 48 << 16, 5 << 16, 1 << 16, 0, 0, 0, 16'h4000, 14'h0, 1, 150, 0};
    rows[10] = '{"ext stop",   0, 0, 48 << 16, 0, 1 << 16, 0, 0, 0, 16'h4000, 14'h0, 0, 40, 1};
    rows[11] = '{"ext ignore", 0, 0, 48 << 16, 0, 1 << 16, 0, 0, 0, 16'h4000, 14'h0, 0, 80, 2};
    wd_cycles = 2000;
    foreach (rows[k]) wd_cycles += rows[k].n * 4;
    repeat (3) @(posedge bus);
    @(negedge bus);
    rst_n = 1'b1;
    for (i = 0; i < ntbl; i++) begin
      rng = xorshift(rng);
      tbl[i] = int'($signed(rng[13:0]));
      bus_write(1, 8'(i << 2), rng);
    end
    e0 = errors;
    check_regs();
    $display("test 0 register readback: %0d errors", errors - e0);
    for (i = 0; i < nrows; i++) begin
      e0 = errors;
      run_row(rows[i]);
      $display("test %0d %s: %0d errors", i + 1, rows[i].name, errors - e0);
    end
    $display("tests %0d, checks %0d, errors %0d", nrows + 1, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the rows
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge bus);
    $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
